// File: hw/lsu_pkg.sv
package lsu_pkg;

  // one 32-bit word of four byte lanes
  localparam int data_width_c = 32;
  localparam int mask_width_c = data_width_c / 8;

  // struct field widths
  // lsu_top and the modules below it assume these widths; mem_words_p
  // must stay at or below 2**(addr_width_c-2) so the word index fits the address
  localparam int id_width_c   = 4;
  localparam int addr_width_c = 12;

  typedef enum logic [3:0] {
    LB  = 4'h0,
    LH  = 4'h1,
    LW  = 4'h2,
    LBU = 4'h3,
    LHU = 4'h4,
    SB  = 4'h8,
    SH  = 4'h9,
    SW  = 4'ha,
    SM  = 4'hb   // masked store with lanes from req mask
  } lsu_op_e;

  typedef struct packed {
    lsu_op_e                   opcode;
    logic [id_width_c-1:0]     id;
    logic [addr_width_c-1:0]   addr;   // byte address
    logic [data_width_c-1:0]   data;
    logic [mask_width_c-1:0]   mask;   // only used by SM
  } lsu_req_s;

  typedef struct packed {
    logic [id_width_c-1:0]     id;
    logic [data_width_c-1:0]   data;   // zero for stores
  } lsu_resp_s;

endpackage

// File: hw/store_align.sv
`timescale 1ns/10ps

module store_align
  (
    input  lsu_pkg::lsu_op_e                    opcode_i
    , input  logic [1:0]                        byte_off_i
    , input  logic [lsu_pkg::data_width_c-1:0]  data_i
    , input  logic [lsu_pkg::mask_width_c-1:0]  mask_i
    , output logic [lsu_pkg::data_width_c-1:0]  wdata_o
    , output logic [lsu_pkg::mask_width_c-1:0]  wmask_o
  );

  import lsu_pkg::*;

  always_comb begin
    wdata_o = '0;
    wmask_o = '0;
    case (opcode_i)
      SW: begin
        wdata_o = data_i;
        wmask_o = '1;
      end
      SH: begin
        wdata_o = {2{data_i[15:0]}};
        // bit 1 picks the upper or lower half
        wmask_o = byte_off_i[1] ? 4'b1100 : 4'b0011;
      end
      SB: begin
        wdata_o = {4{data_i[7:0]}};
        wmask_o = 4'b0001 << byte_off_i;
      end
      SM: begin
        wdata_o = data_i;
        wmask_o = mask_i;
      end
      default: begin
        // loads write nothing
        wdata_o = '0;
        wmask_o = '0;
      end
    endcase
  end

endmodule

// File: hw/load_extract.sv
`timescale 1ns/10ps

module load_extract
  (
    input  lsu_pkg::lsu_op_e                    opcode_i
    , input  logic [1:0]                        byte_off_i
    , input  logic [lsu_pkg::data_width_c-1:0]  word_i
    , output logic [lsu_pkg::data_width_c-1:0]  data_o
  );

  import lsu_pkg::*;

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  always_comb begin
    case (byte_off_i)
      2'd0:    byte_sel = word_i[7:0];
      2'd1:    byte_sel = word_i[15:8];
      2'd2:    byte_sel = word_i[23:16];
      default: byte_sel = word_i[31:24];
    endcase
  end

  assign half_sel = byte_off_i[1] ? word_i[31:16] : word_i[15:0];

  always_comb begin
    case (opcode_i)
      LW:      data_o = word_i;
      LH:      data_o = {{16{half_sel[15]}}, half_sel};
      LB:      data_o = {{24{byte_sel[7]}}, byte_sel};
      LHU:     data_o = {16'b0, half_sel};
      LBU:     data_o = {24'b0, byte_sel};
      default: data_o = '0;  // stores answer with zero
    endcase
  end

endmodule

// File: hw/data_bank.sv
`timescale 1ns/10ps

module data_bank
  #(parameter int mem_words_p = 256
    , localparam int lg_words_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1
  )
  (
    input  logic                                clk_i
    , input  logic                              reset_i
    , input  logic [lg_words_lp-1:0]            addr_i
    , input  logic [lsu_pkg::mask_width_c-1:0]  wmask_i
    , input  logic [lsu_pkg::data_width_c-1:0]  wdata_i
    , output logic [lsu_pkg::data_width_c-1:0]  rdata_o
  );

  import lsu_pkg::*;

  logic [data_width_c-1:0] mem_r [mem_words_p];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int w = 0; w < mem_words_p; w++) begin
        mem_r[w] <= '0;
      end
    end else begin
      for (int i = 0; i < mask_width_c; i++) begin
        if (wmask_i[i]) begin
          mem_r[addr_i][8*i+:8] <= wdata_i[8*i+:8];
        end
      end
    end
  end

  // read sees the value before a same-edge write
  always_ff @(posedge clk_i) begin
    rdata_o <= mem_r[addr_i];
  end

endmodule

// File: hw/resp_fifo.sv
`timescale 1ns/10ps

module resp_fifo
  #(parameter int fifo_els_p = 4
    , localparam int count_width_lp = $clog2(fifo_els_p+1)
    , localparam int ptr_width_lp = $clog2(fifo_els_p)
  )
  (
    input  logic                        clk_i
    , input  logic                      reset_i
    , input  logic                      push_i
    , input  lsu_pkg::lsu_resp_s        push_data_i
    , output lsu_pkg::lsu_resp_s        resp_o
    , output logic                      v_o
    , input  logic                      yumi_i
    , output logic [count_width_lp-1:0] count_o
  );

  import lsu_pkg::*;

  lsu_resp_s                 mem_r [fifo_els_p];
  logic [ptr_width_lp-1:0]   rd_ptr_r, wr_ptr_r;
  logic [count_width_lp-1:0] count_r;
  logic                      pop;

  function automatic logic [ptr_width_lp-1:0] ptr_inc(input logic [ptr_width_lp-1:0] p);
    logic [ptr_width_lp-1:0] nxt;
    if (p == ptr_width_lp'(fifo_els_p-1)) begin
      nxt = '0;  // depth need not be a power of two
    end else begin
      nxt = p + 1'b1;
    end
    return nxt;
  endfunction

  assign v_o     = (count_r != '0);
  assign pop     = yumi_i & v_o;
  assign resp_o  = mem_r[rd_ptr_r];
  assign count_o = count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_r <= ptr_inc(wr_ptr_r);
      end
      if (pop) begin
        rd_ptr_r <= ptr_inc(rd_ptr_r);
      end
      case ({push_i, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;  // both or neither
      endcase
    end
  end

  // upstream credit keeps pushes off a full queue
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_r[wr_ptr_r] <= push_data_i;
    end
  end

endmodule

// File: hw/lsu_pipe.sv
`timescale 1ns/10ps

module lsu_pipe
  #(parameter int mem_words_p = 256
    , parameter int fifo_els_p = 4
    , localparam int count_width_lp = $clog2(fifo_els_p+1)
    , localparam int lg_words_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1
  )
  (
    input  logic                        clk_i
    , input  logic                      reset_i
    , input  lsu_pkg::lsu_req_s         req_i
    , input  logic                      v_i
    , output logic                      ready_o
    , output logic                      push_o
    , output lsu_pkg::lsu_resp_s        push_data_o
    , input  logic [count_width_lp-1:0] fifo_count_i
  );

  import lsu_pkg::*;

  logic                    accept;
  logic [data_width_c-1:0] st_wdata;
  logic [mask_width_c-1:0] st_wmask;
  logic [mask_width_c-1:0] bank_wmask;
  logic [data_width_c-1:0] rd_word;
  logic [data_width_c-1:0] ld_data;
  logic [count_width_lp:0] credit_used;  // one bit wider than the count

  // stage 1
  logic                  s1_v_r;
  lsu_op_e               s1_op_r;
  logic [id_width_c-1:0] s1_id_r;
  logic [1:0]            s1_off_r;

  // queued entries plus the one pushing this cycle
  assign credit_used = fifo_count_i + s1_v_r;
  assign ready_o     = credit_used < fifo_els_p;
  assign accept      = v_i & ready_o;

  store_align align (
    .opcode_i   (req_i.opcode)
    ,.byte_off_i(req_i.addr[1:0])
    ,.data_i    (req_i.data)
    ,.mask_i    (req_i.mask)
    ,.wdata_o   (st_wdata)
    ,.wmask_o   (st_wmask)
  );

  assign bank_wmask = accept ? st_wmask : '0;

  data_bank #(
    .mem_words_p(mem_words_p)
  ) bank (
    .clk_i   (clk_i)
    ,.reset_i(reset_i)
    ,.addr_i (req_i.addr[lg_words_lp+1:2])
    ,.wmask_i(bank_wmask)
    ,.wdata_i(st_wdata)
    ,.rdata_o(rd_word)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_r <= 1'b0;
    end else begin
      s1_v_r <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      s1_op_r  <= req_i.opcode;
      s1_id_r  <= req_i.id;
      s1_off_r <= req_i.addr[1:0];
    end
  end

  load_extract extract (
    .opcode_i   (s1_op_r)
    ,.byte_off_i(s1_off_r)
    ,.word_i    (rd_word)
    ,.data_o    (ld_data)
  );

  assign push_o           = s1_v_r;  // one push per accepted request
  assign push_data_o.id   = s1_id_r;
  assign push_data_o.data = ld_data;

endmodule

// File: hw/lsu_top.sv
`timescale 1ns/10ps

module lsu_top
  #(parameter int mem_words_p = 256
    , parameter int fifo_els_p = 4   // at least 2
    , localparam int count_width_lp = $clog2(fifo_els_p+1)
  )
  (
    input  logic                  clk_i
    , input  logic                reset_i

    , input  lsu_pkg::lsu_req_s   req_i
    , input  logic                v_i
    , output logic                ready_o

    , output lsu_pkg::lsu_resp_s  resp_o
    , output logic                v_o
    , input  logic                yumi_i
  );

  logic                      push;
  lsu_pkg::lsu_resp_s        push_data;
  logic [count_width_lp-1:0] fifo_count;

  // request side, bank and load/store shaping
  lsu_pipe #(
    .mem_words_p(mem_words_p)
    ,.fifo_els_p(fifo_els_p)
  ) pipe (
    .clk_i        (clk_i)
    ,.reset_i     (reset_i)
    ,.req_i       (req_i)
    ,.v_i         (v_i)
    ,.ready_o     (ready_o)
    ,.push_o      (push)
    ,.push_data_o (push_data)
    ,.fifo_count_i(fifo_count)
  );

  // responses leave in acceptance order
  resp_fifo #(
    .fifo_els_p(fifo_els_p)
  ) fifo (
    .clk_i       (clk_i)
    ,.reset_i    (reset_i)
    ,.push_i     (push)
    ,.push_data_i(push_data)
    ,.resp_o     (resp_o)
    ,.v_o        (v_o)
    ,.yumi_i     (yumi_i)
    ,.count_o    (fifo_count)
  );

endmodule

// File: sim/lsu_sva.sv
`timescale 1ns/10ps

module lsu_sva
  (
    input  logic                 clk_i
    , input  logic               reset_i
    , input  logic               ready_o
    , input  lsu_pkg::lsu_resp_s resp_o
    , input  logic               v_o
    , input  logic               yumi_i
  );

  // consumer only takes what is offered
  yumi_needs_v: assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o)
    else $error("yumi_i high while v_o is low");

  resp_holds: assert property (@(posedge clk_i) disable iff (reset_i)
      (v_o && !yumi_i) |=> $stable(resp_o))
    else $error("resp_o changed while waiting for yumi_i");

  // empty pipe and queue once reset has been seen
  reset_state: assert property (@(posedge clk_i) reset_i |=> (ready_o && !v_o))
    else $error("ready_o or v_o wrong right after reset");

endmodule

bind lsu_top lsu_sva sva (
  .clk_i   (clk_i)
  ,.reset_i(reset_i)
  ,.ready_o(ready_o)
  ,.resp_o (resp_o)
  ,.v_o    (v_o)
  ,.yumi_i (yumi_i)
);

// File: sim/lsu_tb.sv
`timescale 1ns/10ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int  mem_words_c  = 256;
  localparam int  fifo_els_c   = 4;
  localparam int  mem_bytes_c  = mem_words_c * 4;
  localparam real clk_period_c = 40.0;

  localparam int n_reset_loads_c = 16;
  localparam int n_pairs_c       = 16;  // store then load
  localparam int n_masked_c      = 8;
  localparam int n_b2b_c         = 8;
  localparam int n_held_c        = 12;
  localparam int n_random_c      = 200;
  localparam int total_reqs_c    = n_reset_loads_c + 2 * n_pairs_c + 2 * n_masked_c
                                   + 2 * n_b2b_c + n_held_c + n_random_c;

  logic      clk_i = 1'b0;
  logic      reset_i;
  lsu_req_s  req;
  logic      req_v;
  logic      ready;
  lsu_resp_s resp;
  logic      resp_v;
  logic      yumi;

  int                    seed = 28283;
  int                    yumi_seed;
  int                    yumi_pct;   // chance of taking an offered response
  logic                  yumi_hold;
  logic                  stall_seen;
  logic [id_width_c-1:0] next_id;
  logic [7:0]            shadow [mem_bytes_c];
  lsu_resp_s             exp_q [$];

  lsu_op_e load_ops  [5] = '{LB, LH, LW, LBU, LHU};
  lsu_op_e store_ops [4] = '{SB, SH, SW, SM};
  lsu_op_e all_ops   [9] = '{LB, LH, LW, LBU, LHU, SB, SH, SW, SM};

  lsu_top #(
    .mem_words_p(mem_words_c)
    ,.fifo_els_p(fifo_els_c)
  ) dut (
    .clk_i   (clk_i)
    ,.reset_i(reset_i)
    ,.req_i  (req)
    ,.v_i    (req_v)
    ,.ready_o(ready)
    ,.resp_o (resp)
    ,.v_o    (resp_v)
    ,.yumi_i (yumi)
  );

  always #(clk_period_c / 2) clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "stopping at first error");
  endtask

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic lsu_req_s make_req(input lsu_op_e op, input int addr);
    lsu_req_s r;
    r.opcode = op;
    r.id     = next_id;
    r.addr   = addr_width_c'(addr);
    r.data   = $random(seed);
    r.mask   = mask_width_c'($random(seed));
    next_id  = next_id + 1'b1;
    return r;
  endfunction

  // byte-level model that stores update and loads read
  function automatic logic [31:0] shadow_access(input lsu_req_s r);
    int          base;
    int          bl;
    int          hl;
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] res;
    base = ((int'(r.addr) / 4) % mem_words_c) * 4;
    bl   = int'(r.addr[1:0]);
    hl   = r.addr[1] ? 2 : 0;
    b    = shadow[base + bl];
    h    = {shadow[base + hl + 1], shadow[base + hl]};
    res  = '0;
    case (r.opcode)
      SW: begin
        for (int i = 0; i < 4; i++) shadow[base + i] = r.data[8*i+:8];
      end
      SH: begin
        shadow[base + hl]     = r.data[7:0];
        shadow[base + hl + 1] = r.data[15:8];
      end
      SB: shadow[base + bl] = r.data[7:0];
      SM: begin
        for (int i = 0; i < 4; i++) begin
          if (r.mask[i]) shadow[base + i] = r.data[8*i+:8];
        end
      end
      LW:  res = {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
      LH:  res = {{16{h[15]}}, h};
      LHU: res = {16'h0000, h};
      LB:  res = {{24{b[7]}}, b};
      LBU: res = {24'h000000, b};
      default: res = '0;
    endcase
    return res;
  endfunction

  // entered at posedge+2 and left at posedge+2 after the accept edge
  task automatic issue(input lsu_req_s r);
    lsu_resp_s e;
    req   = r;
    req_v = 1'b1;
    @(negedge clk_i);
    while (!ready) begin
      @(negedge clk_i);
    end
    e.id   = r.id;
    e.data = shadow_access(r);
    exp_q.push_back(e);
    @(posedge clk_i);
    #2;
    req_v = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  always @(posedge clk_i) begin
    logic hold_now;
    int   pct_now;
    hold_now = yumi_hold;  // as left by the previous cycle
    pct_now  = yumi_pct;
    #2;
    if (reset_i || hold_now) begin
      yumi = 1'b0;
    end else begin
      yumi = resp_v && ((($random(yumi_seed) & 32'h7fff_ffff) % 100) < pct_now);
    end
  end

  always @(negedge clk_i) begin
    if (req_v && !ready) stall_seen = 1'b1;
  end

  // compare each taken response against the oldest expected one
  always @(negedge clk_i) begin
    lsu_resp_s expd;
    if (!reset_i && resp_v && yumi) begin
      assert (exp_q.size() != 0)
        else fail_run("a response arrived with no request outstanding");
      expd = exp_q.pop_front();
      assert (resp.id == expd.id)
        else fail_run($sformatf("CHECK FAILED resp.id got %h expected %h", resp.id, expd.id));
      assert (resp.data == expd.data)
        else fail_run($sformatf("CHECK FAILED resp.data got %h expected %h (id %h)",
                                resp.data, expd.data, expd.id));
    end
  end

  initial begin
    #(total_reqs_c * 20 * clk_period_c);
    fail_run($sformatf("timeout: the run did not finish within %0d clock periods",
                       total_reqs_c * 20));
  end

  initial begin
    int addr;
    for (int a = 0; a < mem_bytes_c; a++) shadow[a] = 8'h00;
    yumi_seed  = seed + 1;
    reset_i    = 1'b1;
    req        = '0;
    req_v      = 1'b0;
    yumi       = 1'b0;
    yumi_pct   = 100;
    yumi_hold  = 1'b0;
    stall_seen = 1'b0;
    next_id    = '0;
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    // bank starts cleared
    for (int i = 0; i < n_reset_loads_c; i++) begin
      issue(make_req(load_ops[i % 5], rand_below(mem_bytes_c)));
    end

    // walks every store and load pairing
    for (int i = 0; i < n_pairs_c; i++) begin
      addr = rand_below(mem_bytes_c);
      issue(make_req(store_ops[i % 3], addr));
      idle(1);
      issue(make_req(load_ops[i % 5], addr));
    end

    yumi_pct = 70;
    for (int i = 0; i < n_masked_c; i++) begin
      addr = rand_below(mem_bytes_c);
      issue(make_req(SM, addr));
      issue(make_req(LW, addr));
    end

    yumi_pct = 100;
    for (int i = 0; i < n_b2b_c; i++) begin
      addr = rand_below(mem_bytes_c);
      issue(make_req(store_ops[rand_below(4)], addr));
      issue(make_req(load_ops[rand_below(5)], addr));  // no gap
    end

    // consumer stalls until queue and pipe fill up
    yumi_hold  = 1'b1;
    stall_seen = 1'b0;
    fork
      begin
        for (int i = 0; i < n_held_c; i++) begin
          issue(make_req(all_ops[rand_below(9)], rand_below(64)));
        end
      end
      begin
        repeat (30) @(posedge clk_i);
        #2;
        assert (stall_seen)
          else fail_run("ready_o never fell while responses were held back");
        yumi_hold = 1'b0;
      end
    join

    // small address window so stores and loads collide
    yumi_pct = 50;
    for (int i = 0; i < n_random_c; i++) begin
      issue(make_req(all_ops[rand_below(9)], rand_below(64)));
      idle(rand_below(3));
    end

    yumi_pct = 100;
    while (exp_q.size() != 0) @(posedge clk_i);
    idle(4);
    assert (!resp_v)
      else fail_run("an extra response is still offered after every request was answered");
    $display("** PASS **");
    $finish;
  end

endmodule

// File: all.f
hw/lsu_pkg.sv
hw/store_align.sv
hw/load_extract.sv
hw/data_bank.sv
hw/resp_fifo.sv
hw/lsu_pipe.sv
hw/lsu_top.sv
sim/lsu_sva.sv
sim/lsu_tb.sv
